// ==== rv_defs.svh ====
/*
  core-wide width and size macros
  data width, register index width, reset pc, instruction memory depth
*/
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// rv64 data path and pc width
`define XLEN 64

// 32 architectural registers
`define REG_IDX_W 5

// first fetch address after reset
`define PC_RESET 64'h0000_0000_0000_0000

// log2 of instruction memory words
// 6 gives 64 words, 256 bytes
`define IMEM_AW 6

`endif

// ==== rv_types_pkg.sv ====
/*
  instruction-level types
  data, index, instruction and memory address vectors
  alu op, operand select, jump kind enums and the decoded instruction struct
*/
`default_nettype none

`include "rv_defs.svh"

package rv_types_pkg;

  // data word or pc
  typedef logic [`XLEN-1:0] xlen_t;
  // register index
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  // raw 32-bit instruction word
  typedef logic [31:0] inst_t;
  // word index into instruction memory
  typedef logic [`IMEM_AW-1:0] imem_addr_t;

  // pass b is for lui
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_B
  } alu_op_t;

  // operand a source
  typedef enum logic {
    OP_A_RS1,
    OP_A_PC
  } op_a_sel_t;

  typedef enum logic [1:0] {
    JMP_NONE,
    JMP_JAL,
    JMP_JALR
  } jump_kind_t;

  // everything the datapath needs from one instruction
  typedef struct packed {
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      imm;
    alu_op_t    alu_op;
    op_a_sel_t  op_a_sel;
    logic       use_imm;
    logic       writes_rd;
    jump_kind_t jump_kind;
    logic       is_ebreak;
    logic       is_illegal;
  } decoded_t;

endpackage

`default_nettype wire

// ==== core_state_pkg.sv ====
/*
  core-level types
  run state enum and retire trace record
*/
`default_nettype none

package core_state_pkg;

  // halted after ebreak, trapped after an illegal word
  typedef enum logic [1:0] {
    ST_RUN,
    ST_HALTED,
    ST_TRAPPED
  } run_state_t;

  // one record per retired instruction
  typedef struct packed {
    logic                   valid;
    rv_types_pkg::xlen_t    pc;
    rv_types_pkg::inst_t    inst;
    // rd_we low for ebreak and for no-write instructions
    logic                   rd_we;
    rv_types_pkg::reg_idx_t rd;
    rv_types_pkg::xlen_t    rd_data;
  } retire_t;

endpackage

`default_nettype wire

// ==== inst_memory.sv ====
/*
  instruction memory
  load write port, combinational fetch by pc word index
*/
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module inst_memory (
  input  logic                     clk,
  input  logic                     we,
  input  rv_types_pkg::imem_addr_t waddr,
  input  rv_types_pkg::inst_t      wdata,
  input  rv_types_pkg::xlen_t      pc,
  input  logic                     run_active,
  output rv_types_pkg::inst_t      inst
);

  // program store, filled during reset
  rv_types_pkg::inst_t mem [0:(1 << `IMEM_AW)-1];

  // drop byte offset, upper bits wrap
  rv_types_pkg::imem_addr_t raddr;

  assign raddr = pc[`IMEM_AW+1:2];

  // load port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch within the same cycle
  assign inst = mem[raddr];

  // loading only while control holds the core in reset
  assert property (@(posedge clk) we |-> !run_active)
    else $error("instruction memory written while the core runs");

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
/*
  instruction decoder
  addi, add, sub, lui, auipc, jal, jalr, ebreak
  all other words flagged illegal
*/
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module inst_decoder (
  input  rv_types_pkg::inst_t    inst,
  output rv_types_pkg::decoded_t dec
);

  // major opcodes in use
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  // ebreak is one exact word
  localparam rv_types_pkg::inst_t EBREAK_WORD = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_types_pkg::xlen_t imm_i;
  rv_types_pkg::xlen_t imm_u;
  rv_types_pkg::xlen_t imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // immediates all sign-extended from bit 31
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  // j-type bits are scrambled and the lsb is zero
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  always_comb begin
    // safe defaults with no write and no jump
    dec = '0;
    dec.rd        = inst[11:7];
    dec.rs1       = inst[19:15];
    dec.rs2       = inst[24:20];
    dec.alu_op    = rv_types_pkg::ALU_ADD;
    dec.op_a_sel  = rv_types_pkg::OP_A_RS1;
    dec.jump_kind = rv_types_pkg::JMP_NONE;

    case (opcode)
      OPC_OP_IMM: begin
        // addi only
        if (funct3 == 3'b000) begin
          dec.imm       = imm_i;
          dec.use_imm   = 1'b1;
          dec.writes_rd = 1'b1;
        end else begin
          dec.is_illegal = 1'b1;
        end
      end
      OPC_OP: begin
        // add and sub differ by funct7 bit 5
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          dec.writes_rd = 1'b1;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          dec.alu_op    = rv_types_pkg::ALU_SUB;
          dec.writes_rd = 1'b1;
        end else begin
          dec.is_illegal = 1'b1;
        end
      end
      OPC_LUI: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = rv_types_pkg::ALU_PASS_B;
        dec.writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.op_a_sel  = rv_types_pkg::OP_A_PC;
        dec.writes_rd = 1'b1;
      end
      OPC_JAL: begin
        // alu forms the jump target pc + imm
        dec.imm       = imm_j;
        dec.use_imm   = 1'b1;
        dec.op_a_sel  = rv_types_pkg::OP_A_PC;
        dec.writes_rd = 1'b1;
        dec.jump_kind = rv_types_pkg::JMP_JAL;
      end
      OPC_JALR: begin
        // target is rs1 + imm from the alu
        if (funct3 == 3'b000) begin
          dec.imm       = imm_i;
          dec.use_imm   = 1'b1;
          dec.writes_rd = 1'b1;
          dec.jump_kind = rv_types_pkg::JMP_JALR;
        end else begin
          dec.is_illegal = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        if (inst == EBREAK_WORD) begin
          dec.is_ebreak = 1'b1;
        end else begin
          dec.is_illegal = 1'b1;
        end
      end
      default: begin
        dec.is_illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== register_file.sv ====
/*
  integer register file
  two combinational reads, one synchronous write, x0 hard zero
*/
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  rv_types_pkg::reg_idx_t rs1,
  input  rv_types_pkg::reg_idx_t rs2,
  output rv_types_pkg::xlen_t    rdata_1,
  output rv_types_pkg::xlen_t    rdata_2,
  input  logic                   we,
  input  rv_types_pkg::reg_idx_t rd,
  input  rv_types_pkg::xlen_t    wdata
);

  rv_types_pkg::xlen_t regs [0:(1 << `REG_IDX_W)-1];

  // write lands at the edge, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < (1 << `REG_IDX_W); i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // same-cycle read of rd returns old value
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

  // x0 storage stays clear across any write sequence
  assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
    else $error("x0 storage is no longer zero");

endmodule

`default_nettype wire

// ==== alu.sv ====
/*
  alu
  operand selection and add, sub, pass-b
*/
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  rv_types_pkg::decoded_t dec,
  input  rv_types_pkg::xlen_t    pc,
  input  rv_types_pkg::xlen_t    rs1_val,
  input  rv_types_pkg::xlen_t    rs2_val,
  output rv_types_pkg::xlen_t    result
);

  rv_types_pkg::xlen_t op_a;
  rv_types_pkg::xlen_t op_b;

  // pc for auipc and jal
  assign op_a = (dec.op_a_sel == rv_types_pkg::OP_A_PC) ? pc : rs1_val;
  // immediate for i and u types
  assign op_b = dec.use_imm ? dec.imm : rs2_val;

  always_comb begin
    case (dec.alu_op)
      rv_types_pkg::ALU_SUB:    result = op_a - op_b;
      // lui passes the immediate
      rv_types_pkg::ALU_PASS_B: result = op_b;
      default:                  result = op_a + op_b;
    endcase
  end

endmodule

`default_nettype wire

// ==== core_control.sv ====
/*
  core control
  pc register and next-pc select, run/halt/trap FSM
  register write-back control and retire trace
*/
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module core_control (
  input  logic                     clk,
  input  logic                     reset,
  input  rv_types_pkg::decoded_t   dec,
  input  rv_types_pkg::inst_t      inst,
  input  rv_types_pkg::xlen_t      alu_result,
  output rv_types_pkg::xlen_t      pc,
  output logic                     rf_we,
  output rv_types_pkg::reg_idx_t   rf_rd,
  output rv_types_pkg::xlen_t      rf_wdata,
  output logic                     run_active,
  output core_state_pkg::retire_t  retire,
  output logic                     halted,
  output logic                     trap,
  output rv_types_pkg::xlen_t      trap_pc
);

  core_state_pkg::run_state_t state;
  core_state_pkg::run_state_t state_next;
  rv_types_pkg::xlen_t pc_plus4;
  rv_types_pkg::xlen_t jal_target;
  rv_types_pkg::xlen_t jalr_target;
  rv_types_pkg::xlen_t pc_next;
  logic is_jump;

  // executing only in run and out of reset
  assign run_active = (state == core_state_pkg::ST_RUN) && !reset;

  assign pc_plus4    = pc + `XLEN'd4;
  // alu forms pc + imm for jal
  assign jal_target  = alu_result;
  // jalr clears bit 0 of rs1 + imm
  assign jalr_target = {alu_result[`XLEN-1:1], 1'b0};
  assign is_jump     = (dec.jump_kind != rv_types_pkg::JMP_NONE);

  // next pc and state
  always_comb begin
    state_next = state;
    pc_next    = pc;
    if (state == core_state_pkg::ST_RUN) begin
      if (dec.is_illegal) begin
        // pc stays on the offending word
        state_next = core_state_pkg::ST_TRAPPED;
      end else if (dec.is_ebreak) begin
        state_next = core_state_pkg::ST_HALTED;
      end else begin
        case (dec.jump_kind)
          rv_types_pkg::JMP_JAL:  pc_next = jal_target;
          rv_types_pkg::JMP_JALR: pc_next = jalr_target;
          default:                pc_next = pc_plus4;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= core_state_pkg::ST_RUN;
      pc      <= `PC_RESET;
      trap_pc <= '0;
    end else begin
      state <= state_next;
      pc    <= pc_next;
      // capture address of the illegal word
      if (state == core_state_pkg::ST_RUN && dec.is_illegal) begin
        trap_pc <= pc;
      end
    end
  end

  // write-back data is the link address for jumps
  assign rf_we    = run_active && !dec.is_illegal && dec.writes_rd;
  assign rf_rd    = dec.rd;
  assign rf_wdata = is_jump ? pc_plus4 : alu_result;

  assign halted = (state == core_state_pkg::ST_HALTED);
  assign trap   = (state == core_state_pkg::ST_TRAPPED);

  // ebreak retires, illegal words do not
  always_comb begin
    retire.valid   = run_active && !dec.is_illegal;
    retire.pc      = pc;
    retire.inst    = inst;
    retire.rd_we   = rf_we;
    retire.rd      = dec.rd;
    retire.rd_data = rf_wdata;
  end

  // jump targets and reset pc keep word alignment
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc lost 4-byte alignment");

  // halt is sticky until reset and never turns into a trap
  assert property (@(posedge clk) disable iff (reset) halted |=> halted && !trap)
    else $error("halted core left halt or trapped");

endmodule

`default_nettype wire

// ==== rv_core_top.sv ====
/*
  rv64i single-cycle core top
  instruction memory, decoder, register file, alu, control
*/
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     imem_we,
  input  rv_types_pkg::imem_addr_t imem_addr,
  input  rv_types_pkg::inst_t      imem_wdata,
  output core_state_pkg::retire_t  retire,
  output logic                     halted,
  output logic                     trap,
  output rv_types_pkg::xlen_t      trap_pc
);

  rv_types_pkg::xlen_t    pc;
  rv_types_pkg::inst_t    inst;
  rv_types_pkg::decoded_t dec;
  rv_types_pkg::xlen_t    rdata_1;
  rv_types_pkg::xlen_t    rdata_2;
  rv_types_pkg::xlen_t    alu_result;
  logic                   rf_we;
  rv_types_pkg::reg_idx_t rf_rd;
  rv_types_pkg::xlen_t    rf_wdata;
  logic                   run_active;

  // fetch
  inst_memory u_inst_memory (
    .clk        (clk),
    .we         (imem_we),
    .waddr      (imem_addr),
    .wdata      (imem_wdata),
    .pc         (pc),
    .run_active (run_active),
    .inst       (inst)
  );

  // decode
  inst_decoder u_inst_decoder (
    .inst (inst),
    .dec  (dec)
  );

  // operands and write-back
  register_file u_register_file (
    .clk     (clk),
    .reset   (reset),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .we      (rf_we),
    .rd      (rf_rd),
    .wdata   (rf_wdata)
  );

  // execute
  alu u_alu (
    .dec     (dec),
    .pc      (pc),
    .rs1_val (rdata_1),
    .rs2_val (rdata_2),
    .result  (alu_result)
  );

  // pc, state, retire
  core_control u_core_control (
    .clk        (clk),
    .reset      (reset),
    .dec        (dec),
    .inst       (inst),
    .alu_result (alu_result),
    .pc         (pc),
    .rf_we      (rf_we),
    .rf_rd      (rf_rd),
    .rf_wdata   (rf_wdata),
    .run_active (run_active),
    .retire     (retire),
    .halted     (halted),
    .trap       (trap),
    .trap_pc    (trap_pc)
  );

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
/*
  testbench for the rv64i single-cycle core
  random program generation, load through the write port, isa model
  retire and status compare tasks, cycle limit
*/
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core;

  localparam int NUM_PROGS = 12;
  // run, reset, load and margin cycles per program
  localparam int MAX_CYCLES = NUM_PROGS * (64 + 8 + 64 + 16);
  localparam rv_types_pkg::inst_t EBREAK_WORD = 32'h0010_0073;

  logic                     clk;
  logic                     reset;
  logic                     imem_we;
  rv_types_pkg::imem_addr_t imem_addr;
  rv_types_pkg::inst_t      imem_wdata;
  core_state_pkg::retire_t  retire;
  logic                     halted;
  logic                     trap;
  rv_types_pkg::xlen_t      trap_pc;

  integer seed = 32'hb80d;
  int cycles = 0;
  // program image as loaded into the DUT
  rv_types_pkg::inst_t prog [0:(1 << `IMEM_AW)-1];
  // isa model state
  rv_types_pkg::xlen_t model_regs [0:31];
  rv_types_pkg::xlen_t model_pc;

  rv_core_top DUT (
    .clk        (clk),
    .reset      (reset),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .retire     (retire),
    .halted     (halted),
    .trap       (trap),
    .trap_pc    (trap_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  // hard stop if a program never ends
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_on_error("Timeout: the core did not reach the end of all programs in time");
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // valid and rd_we always compared, other fields only when retiring
  task automatic check_retire(input core_state_pkg::retire_t got,
                              input core_state_pkg::retire_t exp);
    if (got.valid !== exp.valid) report_mismatch("retire.valid", got.valid, exp.valid);
    if (got.rd_we !== exp.rd_we) report_mismatch("retire.rd_we", got.rd_we, exp.rd_we);
    if (exp.valid) begin
      if (got.pc !== exp.pc) report_mismatch("retire.pc", got.pc, exp.pc);
      if (got.inst !== exp.inst) report_mismatch("retire.inst", got.inst, exp.inst);
      if (got.rd !== exp.rd) report_mismatch("retire.rd", got.rd, exp.rd);
      if (exp.rd_we && got.rd_data !== exp.rd_data) begin
        report_mismatch("retire.rd_data", got.rd_data, exp.rd_data);
      end
    end
  endtask

  task automatic check_status(input logic exp_halted, input logic exp_trap,
                              input rv_types_pkg::xlen_t exp_trap_pc);
    if (halted !== exp_halted) report_mismatch("halted", halted, exp_halted);
    if (trap !== exp_trap) report_mismatch("trap", trap, exp_trap);
    if (trap_pc !== exp_trap_pc) report_mismatch("trap_pc", trap_pc, exp_trap_pc);
  endtask

  // instruction word builders
  function automatic rv_types_pkg::inst_t i_type_word(input logic [11:0] imm,
      input rv_types_pkg::reg_idx_t rs1, input rv_types_pkg::reg_idx_t rd,
      input logic [6:0] opc);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  function automatic rv_types_pkg::inst_t r_type_word(input logic [6:0] f7,
      input rv_types_pkg::reg_idx_t rs2, input rv_types_pkg::reg_idx_t rs1,
      input rv_types_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic rv_types_pkg::inst_t u_type_word(input logic [19:0] imm,
      input rv_types_pkg::reg_idx_t rd, input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // jal offset bits land scrambled
  function automatic rv_types_pkg::inst_t j_type_word(input logic [20:0] off,
      input rv_types_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // random program with forward jumps only and an ebreak or illegal last word
  task automatic gen_program(output int len);
    integer r;
    int kind;
    int tgt;
    rv_types_pkg::reg_idx_t rd;
    rv_types_pkg::reg_idx_t rs1;
    rv_types_pkg::reg_idx_t rs2;
    len = 4 + ($unsigned($random(seed)) % 60);
    for (int i = 0; i < len - 1; i++) begin
      r = $random(seed);
      rd = r[4:0];
      rs1 = r[9:5];
      rs2 = r[14:10];
      kind = $unsigned($random(seed)) % 8;
      // target somewhere after this word including the terminal
      tgt = i + 1 + ($unsigned($random(seed)) % (len - 1 - i));
      case (kind)
        0, 1: prog[i] = i_type_word(r[31:20], rs1, rd, 7'b0010011);
        2: prog[i] = r_type_word(7'b0000000, rs2, rs1, rd);
        3: prog[i] = r_type_word(7'b0100000, rs2, rs1, rd);
        4: prog[i] = u_type_word(r[31:12], rd, 7'b0110111);
        5: prog[i] = u_type_word(r[31:12], rd, 7'b0010111);
        6: prog[i] = j_type_word(21'((tgt - i) * 4), rd);
        // jalr from x0 is an absolute address
        default: prog[i] = i_type_word(12'(tgt * 4), 5'd0, rd, 7'b1100111);
      endcase
    end
    r = $random(seed);
    // load opcode is outside the supported set
    prog[len-1] = r[0] ? EBREAK_WORD : {r[31:7], 7'b0000011};
  endtask

  // isa model step that predicts one retire record
  task automatic model_exec(input rv_types_pkg::inst_t w,
      output core_state_pkg::retire_t exp, output logic ends_halt, output logic ends_trap);
    logic [6:0] opc;
    logic [2:0] f3;
    rv_types_pkg::xlen_t v1;
    rv_types_pkg::xlen_t v2;
    rv_types_pkg::xlen_t imm_i;
    rv_types_pkg::xlen_t imm_u;
    rv_types_pkg::xlen_t imm_j;
    rv_types_pkg::xlen_t res;
    rv_types_pkg::xlen_t nxt;
    logic wr;
    opc = w[6:0];
    f3 = w[14:12];
    // x0 is never written and reads zero
    v1 = model_regs[w[19:15]];
    v2 = model_regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_u = {{32{w[31]}}, w[31:12], 12'h000};
    imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    res = '0;
    wr = 1'b1;
    nxt = model_pc + 64'd4;
    ends_halt = 1'b0;
    ends_trap = 1'b0;
    if (opc == 7'b0010011 && f3 == 3'b000) begin
      res = v1 + imm_i;
    end else if (opc == 7'b0110011 && f3 == 3'b000 && w[31:25] == 7'b0000000) begin
      res = v1 + v2;
    end else if (opc == 7'b0110011 && f3 == 3'b000 && w[31:25] == 7'b0100000) begin
      res = v1 - v2;
    end else if (opc == 7'b0110111) begin
      res = imm_u;
    end else if (opc == 7'b0010111) begin
      res = model_pc + imm_u;
    end else if (opc == 7'b1101111) begin
      res = model_pc + 64'd4;
      nxt = model_pc + imm_j;
    end else if (opc == 7'b1100111 && f3 == 3'b000) begin
      res = model_pc + 64'd4;
      nxt = (v1 + imm_i) & ~64'd1;
    end else if (w == EBREAK_WORD) begin
      wr = 1'b0;
      ends_halt = 1'b1;
    end else begin
      wr = 1'b0;
      ends_trap = 1'b1;
    end
    exp.valid = !ends_trap;
    exp.pc = model_pc;
    exp.inst = w;
    exp.rd_we = wr;
    exp.rd = w[11:7];
    exp.rd_data = res;
    if (wr && w[11:7] != 5'd0) model_regs[w[11:7]] = res;
    // pc freezes on ebreak and on the illegal word
    if (!ends_halt && !ends_trap) model_pc = nxt;
  endtask

  // 8 plain reset cycles and then the program load under reset
  task automatic load_and_reset(input int len);
    reset = 1'b1;
    imem_we = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #10;
      @(negedge clk);
      check_status(1'b0, 1'b0, '0);
      check_retire(retire, '0);
    end
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      #10;
      imem_we = 1'b1;
      imem_addr = rv_types_pkg::imem_addr_t'(i);
      imem_wdata = prog[i];
    end
    @(posedge clk);
    #10;
    imem_we = 1'b0;
    reset = 1'b0;
  endtask

  // compare each cycle and then a few cycles of the final state
  task automatic run_program();
    core_state_pkg::retire_t exp;
    logic ends_halt;
    logic ends_trap;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc = `PC_RESET;
    ends_halt = 1'b0;
    ends_trap = 1'b0;
    while (!ends_halt && !ends_trap) begin
      @(negedge clk);
      check_status(1'b0, 1'b0, '0);
      model_exec(prog[model_pc[`IMEM_AW+1:2]], exp, ends_halt, ends_trap);
      check_retire(retire, exp);
      @(posedge clk);
      #10;
    end
    repeat (4) begin
      @(negedge clk);
      check_status(ends_halt, ends_trap, ends_trap ? model_pc : '0);
      check_retire(retire, '0);
      @(posedge clk);
      #10;
    end
  endtask

  initial begin
    int len;
    reset = 1'b1;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      gen_program(len);
      load_and_reset(len);
      run_program();
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
rv_types_pkg.sv
core_state_pkg.sv
inst_memory.sv
inst_decoder.sv
register_file.sv
alu.sv
core_control.sv
rv_core_top.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_types_pkg.sv
      - core_state_pkg.sv
      - inst_memory.sv
      - inst_decoder.sv
      - register_file.sv
      - alu.sv
      - core_control.sv
      - rv_core_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
